// ==== logic/debug_settings.svh ====
// debug port settings
`ifndef DEBUG_SETTINGS_SVH
`define DEBUG_SETTINGS_SVH

`default_nettype none

// uart bit period in clocks, short for simulation
`define DBG_CLKS_PER_BIT 8

`define DBG_ADDR_BITS 10            // 1k bytes of debug ram

// command byte codes
`define DBG_CMD_NOP       8'd0
`define DBG_CMD_ECHO      8'd1      // cmd, value
`define DBG_CMD_MEM_WRITE 8'd2      // cmd, addr hi/lo, count hi/lo, data
`define DBG_CMD_MEM_READ  8'd3      // cmd, addr hi/lo, count hi/lo

`default_nettype wire

`endif

// ==== logic/debug_pkg.sv ====
// debug port types

`default_nettype none

package debug_pkg;

    // one byte on a serial stream, valid qualifies data
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } byte_stream_t;

    // single-cycle memory request
    typedef struct packed {
        logic        en;
        logic        write;     // 1 = write, 0 = read
        logic [15:0] addr;      // memory decodes only the low bits
        logic [7:0]  wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== logic/uart_rx.sv ====
// uart receiver, 8N1

`timescale 1ns/1ps
`include "debug_settings.svh"
`default_nettype none

module uart_rx (
    input  logic                    i_clk,
    input  logic                    i_reset_n,
    input  logic                    i_rx,
    output debug_pkg::byte_stream_t o_byte
);

    localparam int CPB = `DBG_CLKS_PER_BIT;
    localparam int CW  = $clog2(CPB);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA  = 2'd2;
    localparam logic [1:0] S_STOP  = 2'd3;

    logic          rx_meta;
    logic          rx_sync;
    logic [1:0]    state;
    logic [CW-1:0] cnt;
    logic [2:0]    bit_idx;
    logic [7:0]    shift;
    logic          rx_valid;
    logic          bit_end;
    logic          start_mid;

    assign bit_end   = (cnt == CW'(CPB - 1));
    assign start_mid = (cnt == CW'(CPB / 2 - 1));

    assign o_byte = '{valid: rx_valid, data: shift};

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            rx_meta  <= 1'b1;               // idle line is high
            rx_sync  <= 1'b1;
            state    <= S_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_meta  <= i_rx;
            rx_sync  <= rx_meta;
            rx_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    if (!rx_sync) begin
                        state <= S_START;
                    end
                end
                S_START: begin
                    if (start_mid) begin
                        cnt   <= '0;
                        // glitch if the line is already back high
                        state <= rx_sync ? S_IDLE : S_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_DATA: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= S_STOP;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_end) begin
                        state    <= S_IDLE;
                        rx_valid <= rx_sync;    // framing error drops the byte
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // lsb first
    always_ff @(posedge i_clk) begin
        if (state == S_DATA && bit_end) begin
            shift <= {rx_sync, shift[7:1]};
        end
    end

    a_valid_pulse: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_byte.valid |=> !o_byte.valid);

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
// uart transmitter, 8N1

`timescale 1ns/1ps
`include "debug_settings.svh"
`default_nettype none

module uart_tx (
    input  logic                    i_clk,
    input  logic                    i_reset_n,
    input  debug_pkg::byte_stream_t i_byte,
    output logic                    o_ready,
    output logic                    o_tx
);

    localparam int CPB = `DBG_CLKS_PER_BIT;
    localparam int CW  = $clog2(CPB);

    logic          busy;
    logic          tx_line;
    logic [CW-1:0] cnt;
    logic [3:0]    bit_cnt;
    logic [8:0]    frame;          // data bits then stop bit
    logic          accept;
    logic          bit_end;

    assign o_ready = !busy;
    assign o_tx    = tx_line;
    assign accept  = i_byte.valid && !busy;
    assign bit_end = (cnt == CW'(CPB - 1));

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            busy    <= 1'b0;
            tx_line <= 1'b1;
            cnt     <= '0;
            bit_cnt <= '0;
        end else if (accept) begin
            busy    <= 1'b1;
            tx_line <= 1'b0;        // start bit
            cnt     <= '0;
            bit_cnt <= '0;
        end else if (busy) begin
            if (bit_end) begin
                cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    busy <= 1'b0;   // stop bit done, line already high
                end else begin
                    tx_line <= frame[0];
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            frame <= {1'b1, i_byte.data};
        end else if (busy && bit_end) begin
            frame <= {1'b1, frame[8:1]};
        end
    end

    // idle line must always be high
    a_idle_high: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_ready |-> o_tx);

endmodule

`default_nettype wire

// ==== logic/debug_mem.sv ====
// debug byte ram

`timescale 1ns/1ps
`include "debug_settings.svh"
`default_nettype none

module debug_mem (
    input  logic                i_clk,
    input  debug_pkg::mem_req_t i_req,
    output logic [7:0]          o_rdata
);

    localparam int DEPTH = 1 << `DBG_ADDR_BITS;

    logic [7:0]                mem [DEPTH];
    logic [`DBG_ADDR_BITS-1:0] index;

    assign index = i_req.addr[`DBG_ADDR_BITS-1:0];     // upper address bits ignored

    always_ff @(posedge i_clk) begin
        if (i_req.en) begin
            if (i_req.write) begin
                mem[index] <= i_req.wdata;
            end else begin
                o_rdata <= mem[index];  // valid the cycle after the request
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/debug_cmd_parser.sv ====
// debug command parser

`timescale 1ns/1ps
`include "debug_settings.svh"
`default_nettype none

module debug_cmd_parser (
    input  logic                    i_clk,
    input  logic                    i_reset_n,
    input  debug_pkg::byte_stream_t i_rx,
    output debug_pkg::byte_stream_t o_tx,
    input  logic                    i_tx_ready,
    output debug_pkg::mem_req_t     o_mem,
    input  logic [7:0]              i_mem_rdata,
    output logic [7:0]              o_cmd,
    output logic [15:0]             o_cmd_bytes_remaining
);

    logic [7:0]  cmd;
    logic [15:0] remaining;
    logic [2:0]  byte_idx;          // saturates at 4, the first data byte
    logic [15:0] addr;
    logic        tx_valid;
    logic [7:0]  tx_data;
    logic        mem_en;
    logic        mem_write;
    logic [7:0]  mem_wdata;
    logic        rd_active;         // read-out phase of MEM_READ
    logic        rd_capture;        // read data arrives this cycle
    logic        new_cmd;
    logic        cmd_byte;
    logic        tx_done;
    logic        rd_issue;
    logic        is_write;
    logic        is_read;
    logic [15:0] hdr_total;

    assign is_write = (cmd == `DBG_CMD_MEM_WRITE);
    assign is_read  = (cmd == `DBG_CMD_MEM_READ);

    assign new_cmd  = i_rx.valid && (remaining == 16'd0);
    // bytes during read-out are dropped
    assign cmd_byte = i_rx.valid && (remaining != 16'd0) && !rd_active;
    assign tx_done  = tx_valid && i_tx_ready;
    assign rd_issue = rd_active && !mem_en && !rd_capture && !tx_valid;

    // count bytes fold into the remaining total
    assign hdr_total = remaining - 16'd1 +
                       ((byte_idx == 3'd2) ? {i_rx.data, 8'h00} : {8'h00, i_rx.data});

    assign o_tx  = '{valid: tx_valid, data: tx_data};
    assign o_mem = '{en: mem_en, write: mem_write, addr: addr, wdata: mem_wdata};

    assign o_cmd                 = cmd;
    assign o_cmd_bytes_remaining = remaining;

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            cmd        <= `DBG_CMD_NOP;
            remaining  <= '0;
            byte_idx   <= '0;
            tx_valid   <= 1'b0;
            mem_en     <= 1'b0;
            mem_write  <= 1'b0;
            rd_active  <= 1'b0;
            rd_capture <= 1'b0;
        end else begin
            mem_en     <= 1'b0;
            rd_capture <= mem_en && !mem_write;

            if (tx_done) begin
                tx_valid <= 1'b0;
            end
            if (rd_capture) begin
                tx_valid <= 1'b1;       // offer read byte
            end

            // one read byte handed over
            if (rd_active && tx_done) begin
                remaining <= remaining - 16'd1;
                if (remaining == 16'd1) begin
                    rd_active <= 1'b0;
                end
            end
            if (rd_issue) begin
                mem_en    <= 1'b1;
                mem_write <= 1'b0;
            end

            if (new_cmd) begin
                cmd      <= i_rx.data;
                byte_idx <= '0;
                case (i_rx.data)
                    `DBG_CMD_ECHO: remaining <= 16'd1;
                    `DBG_CMD_MEM_WRITE,
                    `DBG_CMD_MEM_READ: remaining <= 16'd4;      // header only for now
                    default: remaining <= 16'd0;                // unknown acts as nop
                endcase
            end else if (cmd_byte) begin
                remaining <= remaining - 16'd1;
                if (byte_idx != 3'd4) begin
                    byte_idx <= byte_idx + 3'd1;
                end
                if (cmd == `DBG_CMD_ECHO) begin
                    tx_valid <= 1'b1;
                end else if (is_write || is_read) begin
                    case (byte_idx)
                        3'd2: remaining <= hdr_total;           // count hi
                        3'd3: begin
                            remaining <= hdr_total;             // count lo
                            rd_active <= is_read && (hdr_total != 16'd0);
                        end
                        3'd4: begin
                            mem_en    <= is_write;
                            mem_write <= 1'b1;
                        end
                        default: ;
                    endcase
                end
            end else if (remaining == 16'd0) begin
                cmd <= `DBG_CMD_NOP;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (cmd_byte && (is_write || is_read) && byte_idx == 3'd0) begin
            addr[15:8] <= i_rx.data;
        end else if (cmd_byte && (is_write || is_read) && byte_idx == 3'd1) begin
            addr[7:0] <= i_rx.data;
        end else if ((mem_en && mem_write) || (rd_active && tx_done)) begin
            addr <= addr + 16'd1;       // next address after each data byte
        end

        if (rd_capture) begin
            tx_data <= i_mem_rdata;
        end else if (cmd_byte && cmd == `DBG_CMD_ECHO) begin
            tx_data <= i_rx.data;
        end

        if (cmd_byte && is_write) begin
            mem_wdata <= i_rx.data;
        end
    end

    // reply byte held until the transmitter takes it
    a_tx_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_tx.valid && !i_tx_ready |=> o_tx.valid && $stable(o_tx.data));

    a_no_req_on_capture: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        rd_capture |-> !o_mem.en);

endmodule

`default_nettype wire

// ==== logic/debugger_top.sv ====
// uart debug port top

`timescale 1ns/1ps
`default_nettype none

module debugger_top (
    input  logic        i_clk,
    input  logic        i_reset_n,
    input  logic        i_uart_rx,
    output logic        o_uart_tx,
    output logic [7:0]  o_cmd,
    output logic [15:0] o_cmd_bytes_remaining
);

    debug_pkg::byte_stream_t rx_byte;
    debug_pkg::byte_stream_t tx_byte;
    debug_pkg::mem_req_t     mem_req;
    logic [7:0]              mem_rdata;
    logic                    tx_ready;

    uart_rx u_uart_rx (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_rx      (i_uart_rx),
        .o_byte    (rx_byte)
    );

    debug_cmd_parser u_parser (
        .i_clk                 (i_clk),
        .i_reset_n             (i_reset_n),
        .i_rx                  (rx_byte),
        .o_tx                  (tx_byte),
        .i_tx_ready            (tx_ready),
        .o_mem                 (mem_req),
        .i_mem_rdata           (mem_rdata),
        .o_cmd                 (o_cmd),
        .o_cmd_bytes_remaining (o_cmd_bytes_remaining)
    );

    debug_mem u_mem (
        .i_clk   (i_clk),
        .i_req   (mem_req),
        .o_rdata (mem_rdata)
    );

    uart_tx u_uart_tx (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_byte    (tx_byte),
        .o_ready   (tx_ready),
        .o_tx      (o_uart_tx)
    );

endmodule

`default_nettype wire

// ==== tests/debugger_tb.sv ====
// debug port testbench

`timescale 1ns/1ps
`include "debug_settings.svh"
`default_nettype none

module debugger_tb;

    localparam int CPB        = `DBG_CLKS_PER_BIT;
    localparam int MAX_TESTS  = 16;
    localparam int MAX_BYTES  = 512;
    localparam int REPLY_WAIT = 40 * CPB;      // cycles allowed per reply byte
    localparam int DONE_WAIT  = 60 * CPB;
    localparam int IDLE_GAP   = 25 * CPB;      // room for two stray frames

    logic        i_clk;
    logic        i_reset_n;
    logic        i_uart_rx;
    logic        o_uart_tx;
    logic [7:0]  o_cmd;
    logic [15:0] o_cmd_bytes_remaining;

    // test table, bytes kept in flat pools
    string       test_name   [MAX_TESTS];
    int          host_start  [MAX_TESTS];
    int          host_len    [MAX_TESTS];
    int          reply_start [MAX_TESTS];
    int          reply_len   [MAX_TESTS];
    int          wait_at     [MAX_TESTS];  // host byte sent only once the DUT is idle
    logic [7:0]  exp_cmd     [MAX_TESTS];
    logic [7:0]  host_mem    [MAX_BYTES];
    logic [7:0]  reply_mem   [MAX_BYTES];
    int          num_tests;
    int          host_count;
    int          reply_count;

    logic [7:0]  shadow [1 << `DBG_ADDR_BITS];
    logic [31:0] lfsr;
    logic [7:0]  rx_q [$];                  // bytes seen on o_uart_tx
    logic [7:0]  tx_bits;
    int          error_count;
    int          tests_failed;

    debugger_top DUT (
        .i_clk                 (i_clk),
        .i_reset_n             (i_reset_n),
        .i_uart_rx             (i_uart_rx),
        .o_uart_tx             (o_uart_tx),
        .o_cmd                 (o_cmd),
        .o_cmd_bytes_remaining (o_cmd_bytes_remaining)
    );

    always #20 i_clk = ~i_clk;

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_byte(output logic [7:0] b);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {lfsr[0], v[7:1]};
        end
        b = v;
    endtask

    task automatic new_test(input string name, input logic [7:0] final_cmd);
        test_name[num_tests]   = name;
        host_start[num_tests]  = host_count;
        host_len[num_tests]    = 0;
        reply_start[num_tests] = reply_count;
        reply_len[num_tests]   = 0;
        wait_at[num_tests]     = -1;
        exp_cmd[num_tests]     = final_cmd;
        num_tests++;
    endtask

    task automatic add_host(input logic [7:0] b);
        host_mem[host_count] = b;
        host_count++;
        host_len[num_tests - 1]++;
    endtask

    task automatic add_reply(input logic [7:0] b);
        reply_mem[reply_count] = b;
        reply_count++;
        reply_len[num_tests - 1]++;
    endtask

    task automatic add_header(input logic [7:0] cmd, input logic [15:0] addr, input int count);
        add_host(cmd);
        add_host(addr[15:8]);
        add_host(addr[7:0]);
        add_host(count[15:8]);
        add_host(count[7:0]);
    endtask

    task automatic add_write(input logic [15:0] addr, input int count);
        logic [15:0] a;
        logic [7:0]  b;
        a = addr;
        add_header(`DBG_CMD_MEM_WRITE, addr, count);
        for (int i = 0; i < count; i++) begin
            take_byte(b);
            add_host(b);
            shadow[a[`DBG_ADDR_BITS-1:0]] = b;  // ram sees only the low bits
            a = a + 16'd1;
        end
    endtask

    task automatic add_read(input logic [15:0] addr, input int count);
        logic [15:0] a;
        a = addr;
        add_header(`DBG_CMD_MEM_READ, addr, count);
        for (int i = 0; i < count; i++) begin
            add_reply(shadow[a[`DBG_ADDR_BITS-1:0]]);
            a = a + 16'd1;
        end
    endtask

    task automatic add_echo(input logic [7:0] v);
        add_host(`DBG_CMD_ECHO);
        add_host(v);
        add_reply(v);
    endtask

    task automatic build_table();
        new_test("reset_idle", `DBG_CMD_NOP);
        new_test("nop_unknown", `DBG_CMD_NOP);
        add_host(`DBG_CMD_NOP);
        add_host(8'h5A);
        add_host(8'hFF);
        new_test("echo_values", `DBG_CMD_NOP);
        add_echo(8'h00);
        add_echo(8'hFF);
        add_echo(8'hA5);
        add_echo(8'h3C);
        new_test("write_read", `DBG_CMD_NOP);
        add_write(16'h0120, 16);
        add_read(16'h0120, 16);
        new_test("overlap", `DBG_CMD_NOP);
        add_write(16'h0200, 8);
        add_write(16'h0204, 8);
        add_read(16'h0200, 12);
        new_test("wrap_top", `DBG_CMD_NOP);
        add_write(16'h03FE, 4);
        add_read(16'h03FF, 3);
        new_test("zero_count", `DBG_CMD_NOP);
        add_header(`DBG_CMD_MEM_WRITE, 16'h0010, 0);
        add_header(`DBG_CMD_MEM_READ, 16'h0010, 0);
        new_test("read_then_echo", `DBG_CMD_NOP);
        add_read(16'h0120, 4);
        wait_at[num_tests - 1] = host_len[num_tests - 1];
        add_echo(8'h77);
    endtask

    // one 8N1 frame, lsb first
    task automatic send_byte(input logic [7:0] b);
        logic [7:0] sh;
        sh = b;
        @(negedge i_clk);
        i_uart_rx = 1'b0;
        repeat (CPB) @(negedge i_clk);
        for (int i = 0; i < 8; i++) begin
            i_uart_rx = sh[0];
            sh        = sh >> 1;
            repeat (CPB) @(negedge i_clk);
        end
        i_uart_rx = 1'b1;
        repeat (CPB) @(negedge i_clk);
    endtask

    // tx monitor, samples each bit at its middle
    always begin
        @(negedge i_clk);
        if (i_reset_n && !o_uart_tx) begin
            repeat (CPB / 2) @(negedge i_clk);
            if (o_uart_tx) begin
                $display("ERROR: start bit on the tx line lasted less than half a bit");
                error_count++;
            end else begin
                tx_bits = '0;
                for (int i = 0; i < 8; i++) begin
                    repeat (CPB) @(negedge i_clk);
                    tx_bits = {o_uart_tx, tx_bits[7:1]};
                end
                repeat (CPB) @(negedge i_clk);
                if (!o_uart_tx) begin
                    $display("ERROR: reply frame on the tx line has a low stop bit");
                    error_count++;
                end else begin
                    rx_q.push_back(tx_bits);
                end
            end
        end
    end

    task automatic report_mismatch(input int t, input string what,
                                   input logic [15:0] exp, input logic [15:0] act);
        $display("CHECK FAILED %s: %s expected %h actual %h", test_name[t], what, exp, act);
        error_count++;
    endtask

    task automatic wait_done(input int t);
        int cycles;
        cycles = 0;
        while (o_cmd_bytes_remaining != 16'd0 && cycles < DONE_WAIT) begin
            @(negedge i_clk);
            cycles++;
        end
        if (o_cmd_bytes_remaining != 16'd0) begin
            $display("test %s: timed out waiting for the remaining count to reach zero",
                     test_name[t]);
            error_count++;
        end
    endtask

    task automatic wait_reply(input int t, input int n, output bit ok);
        int cycles;
        cycles = 0;
        while (rx_q.size() < n && cycles < REPLY_WAIT) begin
            @(negedge i_clk);
            cycles++;
        end
        ok = (rx_q.size() >= n);
        if (!ok) begin
            $display("test %s: timed out waiting for reply byte %0d", test_name[t], n - 1);
            error_count++;
        end
    endtask

    task automatic run_test(input int t);
        int         errs_before;
        bit         ok;
        bit         known_first;
        logic [7:0] first;
        errs_before = error_count;
        ok          = 1'b1;
        first       = host_mem[host_start[t]];
        known_first = first inside {`DBG_CMD_ECHO, `DBG_CMD_MEM_WRITE, `DBG_CMD_MEM_READ};
        rx_q.delete();
        for (int i = 0; i < host_len[t]; i++) begin
            if (i == wait_at[t]) begin
                wait_done(t);
            end
            send_byte(host_mem[host_start[t] + i]);
            // header still arriving after the command byte
            if (i == 0 && known_first) begin
                if (o_cmd !== first) begin
                    report_mismatch(t, "o_cmd during header", first, o_cmd);
                end
                if (o_cmd_bytes_remaining == 16'd0) begin
                    $display("CHECK FAILED %s: %s expected nonzero actual 0",
                             test_name[t], "remaining count during header");
                    error_count++;
                end
            end else if (!known_first && o_cmd_bytes_remaining !== 16'd0) begin
                // nop and unknown bytes never open a packet
                report_mismatch(t, "remaining count after nop byte", 16'd0,
                                o_cmd_bytes_remaining);
            end
        end
        for (int j = 0; j < reply_len[t] && ok; j++) begin
            wait_reply(t, j + 1, ok);
        end
        wait_done(t);
        repeat (IDLE_GAP) @(negedge i_clk);
        if (rx_q.size() != reply_len[t]) begin
            report_mismatch(t, "reply count", reply_len[t], rx_q.size());
        end
        for (int j = 0; j < reply_len[t] && j < rx_q.size(); j++) begin
            if (rx_q[j] !== reply_mem[reply_start[t] + j]) begin
                report_mismatch(t, $sformatf("reply byte %0d", j),
                                reply_mem[reply_start[t] + j], rx_q[j]);
            end
        end
        if (o_cmd !== exp_cmd[t]) begin
            report_mismatch(t, "final o_cmd", exp_cmd[t], o_cmd);
        end
        if (o_cmd_bytes_remaining !== 16'd0) begin
            report_mismatch(t, "final remaining count", 16'd0, o_cmd_bytes_remaining);
        end
        if (o_uart_tx !== 1'b1) begin
            report_mismatch(t, "idle tx line", 16'd1, o_uart_tx);
        end
        if (error_count == errs_before) begin
            $display("test %-16s ok    (%0d replies)", test_name[t], rx_q.size());
        end else begin
            $display("test %-16s bad   (%0d errors)", test_name[t], error_count - errs_before);
            tests_failed++;
        end
    endtask

    initial begin
        i_clk        = 1'b0;
        i_reset_n    = 1'b0;
        i_uart_rx    = 1'b1;            // idle line
        error_count  = 0;
        tests_failed = 0;
        num_tests    = 0;
        host_count   = 0;
        reply_count  = 0;
        lfsr         = 32'h6e49250d;
        build_table();
        repeat (10) @(negedge i_clk);
        i_reset_n = 1'b1;
        repeat (4) @(negedge i_clk);
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 num_tests, num_tests - tests_failed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+logic
logic/debug_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/debug_mem.sv
logic/debug_cmd_parser.sv
logic/debugger_top.sv
tests/debugger_tb.sv

// ==== Makefile ====
# Verilator build and run of the debug port testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing -f filelist.f --top-module debugger_tb -Mdir obj_dir -o debugger_sim
	./obj_dir/debugger_sim | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
